// ==== design/net_msg_pkg.sv ====
/* field layout of a ring network message, dest in the top bits
   widths are fixed for an eight-node ring */
`default_nettype none

package net_msg_pkg;

  // ----------------------------------------------------------
  // field widths
  // ----------------------------------------------------------

  // data carried end to end, never inspected by the router
  localparam int unsigned payload_nbits = 8;

  // tag owned by the sender, passed through untouched
  localparam int unsigned opaque_nbits  = 8;

  // node id, enough for num_routers ring positions
  localparam int unsigned srcdest_nbits = 3;

  // ----------------------------------------------------------
  // message word
  // ----------------------------------------------------------

  // 22 bits in total, same order as the val/rdy harness
  typedef struct packed {
    logic [srcdest_nbits-1:0] dest;
    logic [srcdest_nbits-1:0] src;
    logic [opaque_nbits-1:0]  opaque;
    logic [payload_nbits-1:0] payload;
  } net_msg_t;

endpackage

`default_nettype wire

// ==== design/router_cfg_pkg.sv ====
/* router configuration: ring size, port numbering and queue sizing
   queue_depth need not be a power of two */
`default_nettype none

package router_cfg_pkg;

  import net_msg_pkg::*;

  // ring and port layout
  localparam int unsigned num_routers = 8;
  localparam int unsigned num_ports   = 3;
  localparam int unsigned port_nbits  = $clog2(num_ports);

  localparam logic [port_nbits-1:0] port_west = 2'd0;
  localparam logic [port_nbits-1:0] port_term = 2'd1;
  localparam logic [port_nbits-1:0] port_east = 2'd2;

  // ----------------------------------------------------------
  // input queue sizing
  // ----------------------------------------------------------

  localparam int unsigned queue_depth     = 4;
  localparam int unsigned queue_ptr_nbits = $clog2(queue_depth);
  // count has to hold the value queue_depth itself
  localparam int unsigned queue_cnt_nbits = $clog2(queue_depth + 1);

  // message tagged with the output it has to leave on, 24 bits
  typedef struct packed {
    logic [port_nbits-1:0] out_port;
    net_msg_t              msg;
  } routed_msg_t;

endpackage

`default_nettype wire

// ==== design/router_route_stage.sv ====
/* one-entry register stage, one message per cycle when the queue keeps up
   router_id is taken modulo num_routers */
`default_nettype none

module router_route_stage
  import net_msg_pkg::*, router_cfg_pkg::*;
#(
  parameter int unsigned router_id = 0
)
(
  input  logic        clk,
  input  logic        reset,

  input  logic        in_val,
  output logic        in_rdy,
  input  net_msg_t    in_msg,

  output logic        route_val,
  input  logic        route_rdy,
  output routed_msg_t route_msg
);

  logic                  full;
  routed_msg_t           stage_q;
  int unsigned           east_dist;
  logic [port_nbits-1:0] next_port;

  // ----------------------------------------------------------
  // ring routing
  // ----------------------------------------------------------

  // hops needed going east, 0 means the message is for us
  always_comb
  begin
    east_dist = (num_routers + in_msg.dest - router_id % num_routers) % num_routers;
    if (east_dist == 0)
      next_port = port_term;
    else if (east_dist < num_routers / 2)
      next_port = port_east;
    else
      next_port = port_west;
  end

  // accept when empty or when the current entry drains this cycle
  assign in_rdy    = !full || route_rdy;
  assign route_val = full;
  assign route_msg = stage_q;

  always_ff @(posedge clk)
  begin
    if (reset)
      full <= 1'b0;
    else if (in_val && in_rdy)
      full <= 1'b1;
    else if (route_rdy)
      full <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (in_val && in_rdy)
    begin
      stage_q.out_port <= next_port;
      stage_q.msg      <= in_msg;
    end
  end

endmodule

`default_nettype wire

// ==== design/router_input_queue.sv ====
/* circular FIFO of queue_depth routed messages, head read straight from storage
   when full a write is still taken if the head leaves in the same cycle */
`default_nettype none

module router_input_queue
  import router_cfg_pkg::*;
(
  input  logic        clk,
  input  logic        reset,

  input  logic        enq_val,
  output logic        enq_rdy,
  input  routed_msg_t enq_msg,

  output logic        head_val,
  input  logic        head_rdy,
  output routed_msg_t head_msg
);

  routed_msg_t                storage [queue_depth];
  logic [queue_ptr_nbits-1:0] wr_ptr;
  logic [queue_ptr_nbits-1:0] rd_ptr;
  logic [queue_cnt_nbits-1:0] count;
  logic                       do_enq;
  logic                       do_deq;

  // wrap explicitly so a depth other than a power of two works
  function automatic logic [queue_ptr_nbits-1:0] ptr_inc(input logic [queue_ptr_nbits-1:0] ptr);
    if (ptr == queue_depth - 1)
      return '0;
    return ptr + 1'b1;
  endfunction

  assign head_val = (count != 0);
  assign head_msg = storage[rd_ptr];
  assign enq_rdy  = (count != queue_depth) || head_rdy;

  assign do_enq = enq_val && enq_rdy;
  assign do_deq = head_val && head_rdy;

  // ----------------------------------------------------------
  // pointers and occupancy
  // ----------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_enq)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_deq)
        rd_ptr <= ptr_inc(rd_ptr);
      // simultaneous enq and deq leaves the count alone
      if (do_enq && !do_deq)
        count <= count + 1'b1;
      else if (do_deq && !do_enq)
        count <= count - 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk)
  begin
    if (do_enq)
      storage[wr_ptr] <= enq_msg;
  end

endmodule

`default_nettype wire

// ==== design/router_output_arbiter.sv ====
/* round-robin arbiter for one output port, combinational from the queue heads
   a winner stalled by out_rdy stays selected until it transfers */
`default_nettype none

module router_output_arbiter
  import net_msg_pkg::*, router_cfg_pkg::*;
#(
  parameter int unsigned out_port = 0
)
(
  input  logic                          clk,
  input  logic                          reset,

  input  logic        [num_ports-1:0]   head_val,
  input  routed_msg_t [num_ports-1:0]   head_msg,
  output logic        [num_ports-1:0]   grant,

  output logic                          out_val,
  input  logic                          out_rdy,
  output net_msg_t                      out_msg
);

  logic [num_ports-1:0]  req;
  logic [port_nbits-1:0] rr_ptr;
  logic                  locked;
  logic [port_nbits-1:0] locked_idx;
  logic                  pick_found;
  logic [port_nbits-1:0] pick_idx;
  logic [port_nbits-1:0] win_idx;
  int unsigned           scan_idx;

  // only heads addressed to this port compete here
  always_comb
  begin
    for (int i = 0; i < num_ports; i++)
      req[i] = head_val[i] && (head_msg[i].out_port == port_nbits'(out_port));
  end

  // ----------------------------------------------------------
  // round-robin pick, rr_ptr has the highest priority
  // ----------------------------------------------------------

  always_comb
  begin
    pick_found = 1'b0;
    pick_idx   = rr_ptr;
    scan_idx   = 0;
    for (int k = 0; k < num_ports; k++)
    begin
      scan_idx = (rr_ptr + k) % num_ports;
      if (!pick_found && req[scan_idx])
      begin
        pick_found = 1'b1;
        pick_idx   = port_nbits'(scan_idx);
      end
    end
  end

  // a locked head cannot leave its queue, so its request is still up
  assign win_idx = locked ? locked_idx : pick_idx;
  assign out_val = locked || pick_found;
  assign out_msg = head_msg[win_idx].msg;

  always_comb
  begin
    grant = '0;
    if (out_val && out_rdy)
      grant[win_idx] = 1'b1;
  end

  // ----------------------------------------------------------
  // pointer and hold state
  // ----------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rr_ptr     <= '0;
      locked     <= 1'b0;
      locked_idx <= '0;
    end
    else if (out_val && out_rdy)
    begin
      // next search starts just past the input that was served
      rr_ptr <= (win_idx == num_ports - 1) ? '0 : win_idx + 1'b1;
      locked <= 1'b0;
    end
    else if (out_val)
    begin
      locked     <= 1'b1;
      locked_idx <= win_idx;
    end
  end

endmodule

`default_nettype wire

// ==== design/router_top.sv ====
/* one router of the eight-node ring: port 0 west, port 1 terminal, port 2 east
   router_id is this router's ring position, set per instance */
`default_nettype none

module router_top
  import net_msg_pkg::*, router_cfg_pkg::*;
#(
  parameter int unsigned router_id = 0
)
(
  input  logic                       clk,
  input  logic                       reset,

  input  logic     [num_ports-1:0]   in_val,
  output logic     [num_ports-1:0]   in_rdy,
  input  net_msg_t [num_ports-1:0]   in_msg,

  output logic     [num_ports-1:0]   out_val,
  input  logic     [num_ports-1:0]   out_rdy,
  output net_msg_t [num_ports-1:0]   out_msg
);

  // route stage to queue
  logic        [num_ports-1:0] route_val;
  logic        [num_ports-1:0] route_rdy;
  routed_msg_t [num_ports-1:0] route_msg;

  // queue heads toward the arbiters
  logic        [num_ports-1:0] head_val;
  logic        [num_ports-1:0] head_rdy;
  routed_msg_t [num_ports-1:0] head_msg;

  // indexed by arbiter first, then by input
  logic [num_ports-1:0][num_ports-1:0] arb_grant;

  // ----------------------------------------------------------
  // input side
  // ----------------------------------------------------------

  for (genvar i = 0; i < num_ports; i++)
  begin : g_input
    router_route_stage #(
      .router_id (router_id)
    ) i_route (
      .clk       (clk),
      .reset     (reset),
      .in_val    (in_val[i]),
      .in_rdy    (in_rdy[i]),
      .in_msg    (in_msg[i]),
      .route_val (route_val[i]),
      .route_rdy (route_rdy[i]),
      .route_msg (route_msg[i])
    );

    router_input_queue i_queue (
      .clk      (clk),
      .reset    (reset),
      .enq_val  (route_val[i]),
      .enq_rdy  (route_rdy[i]),
      .enq_msg  (route_msg[i]),
      .head_val (head_val[i]),
      .head_rdy (head_rdy[i]),
      .head_msg (head_msg[i])
    );
  end

  // ----------------------------------------------------------
  // output side
  // ----------------------------------------------------------

  for (genvar o = 0; o < num_ports; o++)
  begin : g_output
    router_output_arbiter #(
      .out_port (o)
    ) i_arb (
      .clk      (clk),
      .reset    (reset),
      .head_val (head_val),
      .head_msg (head_msg),
      .grant    (arb_grant[o]),
      .out_val  (out_val[o]),
      .out_rdy  (out_rdy[o]),
      .out_msg  (out_msg[o])
    );
  end

  // each head names one output, so at most one arbiter grants it
  always_comb
  begin
    head_rdy = '0;
    for (int a = 0; a < num_ports; a++)
      head_rdy = head_rdy | arb_grant[a];
  end

endmodule

`default_nettype wire

// ==== verification/router_tb.sv ====
/* testbench for router_top at ring position 2 with all traffic from one $random seed
   sources tag opaque with the input port in the top 2 bits and a 6-bit sequence number */
`default_nettype none

module router_tb
  import net_msg_pkg::*, router_cfg_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned tb_router_id = 2;
  localparam int dir_count  = 16;
  localparam int rand_count = 40;
  localparam int bp_count   = 12;
  localparam int cont_count = 16;
  localparam int total_msgs = num_ports * (dir_count + rand_count + bp_count + cont_count);
  localparam int max_cycles = total_msgs * 20 + 1000;
  // cycles without any delivery before a drain gives up on the rest
  localparam int drain_stall_limit = 100;

  // destination choice of a source
  localparam int mode_all_dest = 0;
  localparam int mode_random   = 1;
  localparam int mode_east     = 2;
  localparam int mode_self     = 3;

  // behavior of the output sinks
  localparam int sink_ready     = 0;
  localparam int sink_random    = 1;
  localparam int sink_hold_east = 2;

  logic                     clk = 1'b0;
  logic                     reset;
  logic     [num_ports-1:0] in_val;
  logic     [num_ports-1:0] in_rdy;
  net_msg_t [num_ports-1:0] in_msg;
  logic     [num_ports-1:0] out_val;
  logic     [num_ports-1:0] out_rdy;
  net_msg_t [num_ports-1:0] out_msg;

  int       seed = 32'hf06bf043;
  int       sink_mode = sink_ready;
  logic     check_fair = 1'b0;
  int       outstanding = 0;
  int       mismatch_count = 0;
  int       error_count = 0;
  int       seq_num [num_ports] = '{default: 0};
  int       wait_cnt [num_ports][num_ports] = '{default: '{default: 0}};
  // one queue per (input, output) pair at index input * num_ports + output
  net_msg_t exp_q [num_ports*num_ports][$];

  router_top #(
    .router_id (tb_router_id)
  ) i_dut (
    .clk     (clk),
    .reset   (reset),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .in_msg  (in_msg),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .out_msg (out_msg)
  );

  always #5 clk = ~clk;

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------

  // own id goes to the terminal, 1..3 hops east go east, the rest west
  function automatic int expected_port(input logic [srcdest_nbits-1:0] dest);
    int east_hops;
    east_hops = (int'(dest) + 8 - int'(tb_router_id)) % 8;
    if (east_hops == 0)
      return 1;
    else if (east_hops <= 3)
      return 2;
    return 0;
  endfunction

  // a waiting input may see at most two grants to others in a row
  task automatic track_fairness(input int o, input int winner);
    for (int i = 0; i < num_ports; i++)
    begin
      // two pending messages mean the older one sits at the queue head
      if (i == winner || exp_q[i*num_ports + o].size() < 2)
        wait_cnt[i][o] = 0;
      else
      begin
        wait_cnt[i][o]++;
        if (wait_cnt[i][o] > 2)
        begin
          $display("Error at %0t: input %0d starved on output %0d for %0d grants",
                   $time, i, o, wait_cnt[i][o]);
          error_count++;
        end
      end
    end
  endtask

  task automatic check_delivery(input int o, input net_msg_t got);
    int       src_port;
    int       idx;
    net_msg_t exp_msg;
    src_port = got.opaque[opaque_nbits-1 -: 2];
    if (src_port >= num_ports)
    begin
      $display("Error at %0t: output %0d delivered a message with no valid input tag",
               $time, o);
      error_count++;
      return;
    end
    if (expected_port(got.dest) != o)
    begin
      $display("Mismatch at %0t: dest %0d left on port %0d, expected port %0d",
               $time, got.dest, o, expected_port(got.dest));
      mismatch_count++;
    end
    idx = src_port * num_ports + o;
    if (exp_q[idx].size() == 0)
    begin
      $display("Error at %0t: output %0d delivered a message from input %0d that was not sent",
               $time, o, src_port);
      error_count++;
      return;
    end
    if (check_fair)
      track_fairness(o, src_port);
    exp_msg = exp_q[idx].pop_front();
    outstanding--;
    if (got !== exp_msg)
    begin
      $display("Mismatch at %0t: output %0d got %h, expected %h from input %0d",
               $time, o, got, exp_msg, src_port);
      mismatch_count++;
    end
  endtask

  // scoreboard samples each transfer at its clock edge
  always @(posedge clk)
  begin
    if (!reset)
    begin
      for (int o = 0; o < num_ports; o++)
      begin
        if (out_val[o] && out_rdy[o])
          check_delivery(o, out_msg[o]);
      end
      for (int i = 0; i < num_ports; i++)
      begin
        if (in_val[i] && in_rdy[i])
        begin
          exp_q[i*num_ports + expected_port(in_msg[i].dest)].push_back(in_msg[i]);
          outstanding++;
        end
      end
    end
  end

  // sinks are ready three cycles out of four in random mode
  always @(posedge clk)
  begin
    for (int o = 0; o < num_ports; o++)
    begin
      if (sink_mode == sink_ready)
        out_rdy[o] <= 1'b1;
      else if (sink_mode == sink_hold_east && o == port_east)
        out_rdy[o] <= 1'b0;
      else
        out_rdy[o] <= ($unsigned($random(seed)) % 4) != 0;
    end
  end

  // ----------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------

  task automatic send_msgs(input int port, input int count, input int max_gap, input int mode);
    net_msg_t msg;
    int       gap;
    for (int k = 0; k < count; k++)
    begin
      gap = $unsigned($random(seed)) % (max_gap + 1);
      repeat (gap) @(posedge clk);
      msg.src     = 3'($random(seed));
      msg.payload = 8'($random(seed));
      msg.opaque  = {2'(port), 6'(seq_num[port])};
      seq_num[port]++;
      case (mode)
        mode_all_dest: msg.dest = 3'(k);
        mode_east:     msg.dest = 3'(3 + $unsigned($random(seed)) % 3);
        mode_self:     msg.dest = 3'(tb_router_id);
        default:       msg.dest = 3'($random(seed));
      endcase
      in_val[port] <= 1'b1;
      in_msg[port] <= msg;
      @(posedge clk);
      while (!in_rdy[port])
        @(posedge clk);
      in_val[port] <= 1'b0;
    end
  endtask

  task automatic run_sources(input int count, input int max_gap, input int mode);
    fork
      send_msgs(0, count, max_gap, mode);
      send_msgs(1, count, max_gap, mode);
      send_msgs(2, count, max_gap, mode);
    join
  endtask

  // leaves once all messages are out or deliveries have stopped
  task automatic wait_drain();
    int last_left;
    int stall;
    last_left = -1;
    stall     = 0;
    do
    begin
      @(negedge clk);
      if (outstanding != last_left)
      begin
        last_left = outstanding;
        stall     = 0;
      end
      else
        stall++;
    end
    while (outstanding != 0 && stall < drain_stall_limit);
    @(posedge clk);
  endtask

  task automatic check_reset_state(input string when_txt);
    if (out_val !== '0 || in_rdy !== '1)
    begin
      $display("Mismatch at %0t: %s reset out_val %b in_rdy %b, expected 000 and 111",
               $time, when_txt, out_val, in_rdy);
      mismatch_count++;
    end
  endtask

  task automatic report_lost();
    net_msg_t lost_msg;
    for (int p = 0; p < num_ports*num_ports; p++)
    begin
      while (exp_q[p].size() != 0)
      begin
        lost_msg = exp_q[p].pop_front();
        $display("Error: message %h from input %0d to output %0d was lost",
                 lost_msg, p / num_ports, p % num_ports);
        error_count++;
      end
    end
  endtask

  initial
  begin
    reset   = 1'b1;
    in_val  = '0;
    in_msg  = '0;
    out_rdy = '1;
    @(posedge clk);
    @(negedge clk);
    check_reset_state("during");
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_reset_state("right after");
    @(posedge clk);

    // every destination from every input including self delivery
    run_sources(dir_count, 2, mode_all_dest);
    wait_drain();

    // random traffic against random sink stalls
    sink_mode <= sink_random;
    run_sources(rand_count, 3, mode_random);
    wait_drain();

    // east output held off while traffic to it keeps coming
    sink_mode <= sink_hold_east;
    fork
      run_sources(bp_count, 1, mode_east);
      begin
        repeat (50) @(posedge clk);
        @(negedge clk);
        if (in_rdy == '1)
        begin
          $display("Error at %0t: back-pressure on the east port never reached the inputs",
                   $time);
          error_count++;
        end
        @(posedge clk);
        sink_mode <= sink_random;
      end
    join
    wait_drain();

    // all inputs burst into the terminal port
    sink_mode  <= sink_ready;
    check_fair <= 1'b1;
    @(posedge clk);
    run_sources(cont_count, 0, mode_self);
    wait_drain();
    check_fair <= 1'b0;

    report_lost();
    $display("Checks done: %0d mismatches, %0d other errors", mismatch_count, error_count);
    if (mismatch_count == 0 && error_count == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // watchdog sized from the total message count
  initial
  begin
    repeat (max_cycles) @(posedge clk);
    $display("Timeout at %0t: run not done after %0d cycles, %0d mismatches, %0d other errors",
             $time, max_cycles, mismatch_count, error_count);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
design/net_msg_pkg.sv
design/router_cfg_pkg.sv
design/router_route_stage.sv
design/router_input_queue.sv
design/router_output_arbiter.sv
design/router_top.sv
verification/router_tb.sv

// ==== Bender.yml ====
package:
  name: ring_router

sources:
  # packages first, then the router from leaf to top
  - files:
      - design/net_msg_pkg.sv
      - design/router_cfg_pkg.sv
      - design/router_route_stage.sv
      - design/router_input_queue.sv
      - design/router_output_arbiter.sv
      - design/router_top.sv
  - target: test
    files:
      - verification/router_tb.sv
